// ==== logic/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

        typedef logic [7:0]  scan_code_t;
        typedef logic [3:0]  key_idx_t;
        typedef logic [15:0] count_t;

        localparam int NUM_KEYS = 10;
        typedef logic [NUM_KEYS-1:0] key_map_t;

        // Receiver gives up on a frame after this many cycles without a clock edge
        localparam int RX_TIMEOUT = 4096;

        localparam scan_code_t PS2_BREAK = 8'hF0;

        // Player 1
        localparam scan_code_t KEY_E   = 8'h24;
        localparam scan_code_t KEY_W   = 8'h1D;
        localparam scan_code_t KEY_A   = 8'h1C;
        localparam scan_code_t KEY_S   = 8'h1B;
        localparam scan_code_t KEY_D   = 8'h23;
        // Player 2, keypad
        localparam scan_code_t KEY_KP7 = 8'h6C;
        localparam scan_code_t KEY_KP8 = 8'h75;
        localparam scan_code_t KEY_KP4 = 8'h6B;
        localparam scan_code_t KEY_KP5 = 8'h73;
        localparam scan_code_t KEY_KP6 = 8'h74;

        function automatic logic key_lookup(input scan_code_t code, output key_idx_t idx);
                logic hit;
                hit = 1'b1;
                idx = '0;
                case (code)
                        KEY_E:   idx = 4'd0;
                        KEY_W:   idx = 4'd1;
                        KEY_A:   idx = 4'd2;
                        KEY_S:   idx = 4'd3;
                        KEY_D:   idx = 4'd4;
                        KEY_KP7: idx = 4'd5;
                        KEY_KP8: idx = 4'd6;
                        KEY_KP4: idx = 4'd7;
                        KEY_KP5: idx = 4'd8;
                        KEY_KP6: idx = 4'd9;
                        default: hit = 1'b0;
                endcase
                return hit;
        endfunction

endpackage

`default_nettype wire

// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

        typedef logic [3:0]  axi_addr_t;
        typedef logic [31:0] axi_data_t;
        typedef logic [1:0]  axi_resp_t;

        localparam axi_resp_t RESP_OKAY   = 2'b00;
        localparam axi_resp_t RESP_SLVERR = 2'b10;

        // Register map
        localparam axi_addr_t REG_KEYS        = 4'h0;
        localparam axi_addr_t REG_LAST_CODE   = 4'h4;
        localparam axi_addr_t REG_PRESS_COUNT = 4'h8;
        localparam axi_addr_t REG_ERR_COUNT   = 4'hC;

endpackage

`default_nettype wire

// ==== logic/key_status_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface key_status_if
        import ps2_pkg::*;
();
        // Decoded key event
        logic       evt_valid;
        key_idx_t   evt_idx;
        logic       evt_release;
        scan_code_t evt_code;

        // Key state and counter clears
        key_map_t   keys;
        scan_code_t last_code;
        count_t     press_count;
        count_t     err_count;
        logic       clr_press;
        logic       clr_err;

        modport event_src (output evt_valid, evt_idx, evt_release, evt_code);
        modport event_dst (input evt_valid, evt_idx, evt_release, evt_code);

        modport status_src (output keys, last_code, press_count, err_count,
                            input clr_press, clr_err);
        modport status_dst (input keys, last_code, press_count, err_count,
                            output clr_press, clr_err);
endinterface

`default_nettype wire

// ==== logic/ps2_frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx
        import ps2_pkg::*;
#(
        parameter int SYNC_STAGES = 2
) (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       ps2_clk,
        input  logic       ps2_data,
        output scan_code_t code,
        output logic       code_valid,
        output logic       frame_err
);

        typedef enum logic [1:0] {
                RX_IDLE,
                RX_DATA,
                RX_PARITY,
                RX_STOP
        } rx_state_t;

        rx_state_t state;
        logic [SYNC_STAGES-1:0] clk_sync;
        logic [SYNC_STAGES-1:0] data_sync;
        logic clk_prev;
        logic clk_s;
        logic data_s;
        logic fall;
        logic [2:0] bit_cnt;
        logic [$clog2(RX_TIMEOUT)-1:0] timer;
        logic start_bit;
        logic parity_bit;
        logic frame_ok;
        scan_code_t shift;

        assign clk_s  = clk_sync[SYNC_STAGES-1];
        assign data_s = data_sync[SYNC_STAGES-1];
        assign fall   = clk_prev & ~clk_s;
        assign code   = shift;

        // Start 0, stop 1 on the current line, odd parity
        assign frame_ok = ~start_bit & data_s & (^{shift, parity_bit});

        // Lines idle high, so the chains come out of reset at 1
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        clk_sync  <= '1;
                        data_sync <= '1;
                        clk_prev  <= 1'b1;
                end else begin
                        clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
                        data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
                        clk_prev  <= clk_s;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state      <= RX_IDLE;
                        bit_cnt    <= '0;
                        timer      <= '0;
                        start_bit  <= 1'b0;
                        parity_bit <= 1'b0;
                        shift      <= '0;
                        code_valid <= 1'b0;
                        frame_err  <= 1'b0;
                end else begin
                        code_valid <= 1'b0;
                        frame_err  <= 1'b0;
                        if (state == RX_IDLE || fall) begin
                                timer <= '0;
                        end else begin
                                timer <= timer + 1'b1;
                        end
                        if (fall) begin
                                case (state)
                                        RX_IDLE: begin
                                                start_bit <= data_s;
                                                bit_cnt   <= '0;
                                                state     <= RX_DATA;
                                        end
                                        RX_DATA: begin
                                                // LSB first
                                                shift   <= {data_s, shift[7:1]};
                                                bit_cnt <= bit_cnt + 1'b1;
                                                if (bit_cnt == 3'd7) begin
                                                        state <= RX_PARITY;
                                                end
                                        end
                                        RX_PARITY: begin
                                                parity_bit <= data_s;
                                                state      <= RX_STOP;
                                        end
                                        default: begin
                                                code_valid <= frame_ok;
                                                frame_err  <= ~frame_ok;
                                                state      <= RX_IDLE;
                                        end
                                endcase
                        end else if (state != RX_IDLE &&
                                     timer == $bits(timer)'(RX_TIMEOUT - 1)) begin
                                state <= RX_IDLE;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/scan_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_decode
        import ps2_pkg::*;
(
        input  logic                   clk,
        input  logic                   rst_n,
        input  scan_code_t             code,
        input  logic                   code_valid,
        input  logic                   frame_err,
        key_status_if.event_src        evt,
        output logic                   err_pulse
);

        typedef enum logic {
                DEC_MAKE,
                DEC_AFTER_BREAK
        } dec_state_t;

        dec_state_t state;
        logic       lut_hit;
        key_idx_t   lut_idx;

        always_comb begin
                lut_hit = key_lookup(code, lut_idx);
        end

        // Errors go straight on so the counter moves one cycle after the frame
        assign err_pulse = frame_err;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state           <= DEC_MAKE;
                        evt.evt_valid   <= 1'b0;
                        evt.evt_idx     <= '0;
                        evt.evt_release <= 1'b0;
                        evt.evt_code    <= '0;
                end else begin
                        evt.evt_valid <= 1'b0;
                        if (frame_err) begin
                                state <= DEC_MAKE;
                        end else if (code_valid) begin
                                if (code == PS2_BREAK) begin
                                        state <= DEC_AFTER_BREAK;
                                end else begin
                                        state <= DEC_MAKE;
                                        if (lut_hit) begin
                                                evt.evt_valid   <= 1'b1;
                                                evt.evt_idx     <= lut_idx;
                                                evt.evt_release <= (state == DEC_AFTER_BREAK);
                                                evt.evt_code    <= code;
                                        end
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/key_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_state
        import ps2_pkg::*;
(
        input  logic              clk,
        input  logic              rst_n,
        key_status_if.event_dst   evt,
        input  logic              err_pulse,
        key_status_if.status_src  st
);

        key_map_t   keys;
        scan_code_t last_code;
        count_t     press_count;
        count_t     err_count;

        assign st.keys        = keys;
        assign st.last_code   = last_code;
        assign st.press_count = press_count;
        assign st.err_count   = err_count;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        keys        <= '0;
                        last_code   <= '0;
                        press_count <= '0;
                        err_count   <= '0;
                end else begin
                        if (evt.evt_valid) begin
                                keys[evt.evt_idx] <= ~evt.evt_release;
                                // Only a 0 to 1 change counts, so typematic repeats fall out
                                if (!evt.evt_release && !keys[evt.evt_idx]) begin
                                        last_code <= evt.evt_code;
                                        if (press_count != '1) begin
                                                press_count <= press_count + 1'b1;
                                        end
                                end
                        end
                        if (err_pulse && err_count != '1) begin
                                err_count <= err_count + 1'b1;
                        end
                        // Clear beats increment
                        if (st.clr_press) begin
                                press_count <= '0;
                        end
                        if (st.clr_err) begin
                                err_count <= '0;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/key_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_axil_regs
        import bus_pkg::*;
(
        input  logic              clk,
        input  logic              rst_n,
        input  axi_addr_t         awaddr,
        input  logic              awvalid,
        output logic              awready,
        input  axi_data_t         wdata,
        input  logic              wvalid,
        output logic              wready,
        output axi_resp_t         bresp,
        output logic              bvalid,
        input  logic              bready,
        input  axi_addr_t         araddr,
        input  logic              arvalid,
        output logic              arready,
        output axi_data_t         rdata,
        output axi_resp_t         rresp,
        output logic              rvalid,
        input  logic              rready,
        key_status_if.status_dst  st
);

        logic wr_accept;
        logic rd_accept;
        logic wr_known;

        assign arready   = ~rvalid;
        assign awready   = ~bvalid;
        assign wready    = ~bvalid;
        assign rd_accept = arvalid & arready;
        assign wr_accept = awvalid & wvalid & ~bvalid;

        // Only the two counters are writable and the data word is don't-care
        assign wr_known     = (awaddr == REG_PRESS_COUNT) || (awaddr == REG_ERR_COUNT);
        assign st.clr_press = wr_accept && (awaddr == REG_PRESS_COUNT);
        assign st.clr_err   = wr_accept && (awaddr == REG_ERR_COUNT);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        rvalid <= 1'b0;
                end else if (rd_accept) begin
                        rvalid <= 1'b1;
                end else if (rready) begin
                        rvalid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (rd_accept) begin
                        rresp <= RESP_OKAY;
                        case (araddr)
                                REG_KEYS:        rdata <= axi_data_t'(st.keys);
                                REG_LAST_CODE:   rdata <= axi_data_t'(st.last_code);
                                REG_PRESS_COUNT: rdata <= axi_data_t'(st.press_count);
                                REG_ERR_COUNT:   rdata <= axi_data_t'(st.err_count);
                                default: begin
                                        rdata <= '0;
                                        rresp <= RESP_SLVERR;
                                end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        bvalid <= 1'b0;
                end else if (wr_accept) begin
                        bvalid <= 1'b1;
                end else if (bready) begin
                        bvalid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (wr_accept) begin
                        bresp <= wr_known ? RESP_OKAY : RESP_SLVERR;
                end
        end

endmodule

`default_nettype wire

// ==== logic/ps2_keypad_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keypad_top
        import ps2_pkg::*;
        import bus_pkg::*;
#(
        parameter int SYNC_STAGES = 2
) (
        input  logic      clk,
        input  logic      rst_n,
        input  logic      ps2_clk,
        input  logic      ps2_data,
        input  axi_addr_t awaddr,
        input  logic      awvalid,
        output logic      awready,
        input  axi_data_t wdata,
        input  logic      wvalid,
        output logic      wready,
        output axi_resp_t bresp,
        output logic      bvalid,
        input  logic      bready,
        input  axi_addr_t araddr,
        input  logic      arvalid,
        output logic      arready,
        output axi_data_t rdata,
        output axi_resp_t rresp,
        output logic      rvalid,
        input  logic      rready
);

        scan_code_t code;
        logic       code_valid;
        logic       frame_err;
        logic       err_pulse;

        key_status_if status_if ();

        ps2_frame_rx #(
                .SYNC_STAGES (SYNC_STAGES)
        ) frame_rx_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .ps2_clk    (ps2_clk),
                .ps2_data   (ps2_data),
                .code       (code),
                .code_valid (code_valid),
                .frame_err  (frame_err)
        );

        scan_decode decode_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .code       (code),
                .code_valid (code_valid),
                .frame_err  (frame_err),
                .evt        (status_if),
                .err_pulse  (err_pulse)
        );

        key_state state_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .evt       (status_if),
                .err_pulse (err_pulse),
                .st        (status_if)
        );

        key_axil_regs regs_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .awaddr  (awaddr),
                .awvalid (awvalid),
                .awready (awready),
                .wdata   (wdata),
                .wvalid  (wvalid),
                .wready  (wready),
                .bresp   (bresp),
                .bvalid  (bvalid),
                .bready  (bready),
                .araddr  (araddr),
                .arvalid (arvalid),
                .arready (arready),
                .rdata   (rdata),
                .rresp   (rresp),
                .rvalid  (rvalid),
                .rready  (rready),
                .st      (status_if)
        );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
        parameter int PERIOD       = 20,
        parameter int RESET_CYCLES = 10
) (
        output logic clk,
        output logic rst_n
);

        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        // Release lands just after an edge, like every other input
        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #2;
                rst_n = 1'b1;
        end

endmodule

`default_nettype wire

// ==== bench/ps2_keypad_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keypad_tb
        import bus_pkg::*;
();

        localparam int HALF_PERIOD = 40;
        localparam int SETTLE      = 50;
        // Upper bound on the frames sent below
        localparam int NUM_FRAMES  = 27;
        localparam int WATCHDOG_CYCLES = NUM_FRAMES * 1000 + 20000;

        logic      clk;
        logic      rst_n;
        logic      ps2_clk;
        logic      ps2_data;
        axi_addr_t awaddr;
        logic      awvalid;
        logic      awready;
        axi_data_t wdata;
        logic      wvalid;
        logic      wready;
        axi_resp_t bresp;
        logic      bvalid;
        logic      bready;
        axi_addr_t araddr;
        logic      arvalid;
        logic      arready;
        axi_data_t rdata;
        axi_resp_t rresp;
        logic      rvalid;
        logic      rready;

        // Game keys in index order: E W A S D, then keypad 7 8 4 5 6
        logic [7:0] key_codes [10] = '{8'h24, 8'h1D, 8'h1C, 8'h1B, 8'h23,
                                       8'h6C, 8'h75, 8'h6B, 8'h73, 8'h74};

        // Reference model
        logic [9:0]  exp_keys;
        logic [7:0]  exp_last;
        logic [15:0] exp_press;
        logic [15:0] exp_err;
        logic        after_break;

        int errors;
        int checks;
        int frames_sent;

        tb_clock clock_i (
                .clk   (clk),
                .rst_n (rst_n)
        );

        ps2_keypad_top #(
                .SYNC_STAGES (2)
        ) ps2_keypad_top_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .ps2_clk  (ps2_clk),
                .ps2_data (ps2_data),
                .awaddr   (awaddr),
                .awvalid  (awvalid),
                .awready  (awready),
                .wdata    (wdata),
                .wvalid   (wvalid),
                .wready   (wready),
                .bresp    (bresp),
                .bvalid   (bvalid),
                .bready   (bready),
                .araddr   (araddr),
                .arvalid  (arvalid),
                .arready  (arready),
                .rdata    (rdata),
                .rresp    (rresp),
                .rvalid   (rvalid),
                .rready   (rready)
        );

        assert property (@(posedge clk) disable iff (!rst_n)
                rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
                errors++;
                $display("Read response changed or dropped while rready was low");
        end

        assert property (@(posedge clk) disable iff (!rst_n)
                bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
                errors++;
                $display("Write response changed or dropped while bready was low");
        end

        assert property (@(posedge clk) disable iff (!rst_n)
                awready == !bvalid && wready == !bvalid)
        else begin
                errors++;
                $display("awready or wready does not follow the pending write response");
        end

        assert property (@(posedge clk) disable iff (!rst_n) arready == !rvalid)
        else begin
                errors++;
                $display("arready does not follow the pending read response");
        end

        task automatic wait_cycles(input int n);
                repeat (n) @(posedge clk);
                #2;
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                checks++;
                assert (got === exp)
                else begin
                        errors++;
                        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
                end
        endtask

        function automatic int find_key(input logic [7:0] code);
                int idx;
                idx = -1;
                for (int k = 0; k < 10; k++) begin
                        if (key_codes[k] == code) begin
                                idx = k;
                        end
                end
                return idx;
        endfunction

        task automatic apply_code(input logic [7:0] code);
                int idx;
                idx = find_key(code);
                if (code == 8'hF0) begin
                        after_break = 1'b1;
                end else begin
                        if (idx >= 0 && after_break) begin
                                exp_keys[idx] = 1'b0;
                        end else if (idx >= 0 && !exp_keys[idx]) begin
                                exp_keys[idx] = 1'b1;
                                exp_last = code;
                                if (exp_press != 16'hFFFF) begin
                                        exp_press = exp_press + 16'd1;
                                end
                        end
                        after_break = 1'b0;
                end
        endtask

        // Start bit, eight data bits LSB first, parity, stop
        task automatic send_frame(input logic [7:0] code, input logic parity,
                                  input logic stop);
                logic [10:0] bits;
                bits = {stop, parity, code, 1'b0};
                for (int i = 0; i < 11; i++) begin
                        ps2_data = bits[i];
                        wait_cycles(HALF_PERIOD);
                        ps2_clk = 1'b0;
                        wait_cycles(HALF_PERIOD);
                        ps2_clk = 1'b1;
                end
                ps2_data = 1'b1;
                wait_cycles(SETTLE);
                frames_sent++;
        endtask

        task automatic read_reg(input axi_addr_t addr, output axi_data_t data,
                                output axi_resp_t resp);
                int delay;
                delay = $urandom_range(0, 3);
                check_value("rvalid", 32'(rvalid), 32'h0);
                araddr  = addr;
                arvalid = 1'b1;
                while (!arready) begin
                        wait_cycles(1);
                end
                wait_cycles(1);
                arvalid = 1'b0;
                check_value("rvalid", 32'(rvalid), 32'h1);
                data = rdata;
                resp = rresp;
                repeat (delay) begin
                        wait_cycles(1);
                        check_value("rvalid", 32'(rvalid), 32'h1);
                        check_value("rdata", rdata, data);
                end
                rready = 1'b1;
                wait_cycles(1);
                rready = 1'b0;
        endtask

        task automatic write_reg(input axi_addr_t addr, input axi_data_t data,
                                 output axi_resp_t resp);
                int delay;
                delay = $urandom_range(0, 3);
                check_value("bvalid", 32'(bvalid), 32'h0);
                awaddr  = addr;
                wdata   = data;
                awvalid = 1'b1;
                wvalid  = 1'b1;
                while (!(awready && wready)) begin
                        wait_cycles(1);
                end
                wait_cycles(1);
                awvalid = 1'b0;
                wvalid  = 1'b0;
                check_value("bvalid", 32'(bvalid), 32'h1);
                resp = bresp;
                repeat (delay) begin
                        wait_cycles(1);
                end
                bready = 1'b1;
                wait_cycles(1);
                bready = 1'b0;
        endtask

        task automatic check_read(input axi_addr_t addr, input string name,
                                  input logic [31:0] exp);
                axi_data_t data;
                axi_resp_t resp;
                read_reg(addr, data, resp);
                check_value(name, data, exp);
                check_value("rresp", 32'(resp), 32'(RESP_OKAY));
        endtask

        task automatic check_registers();
                check_read(REG_KEYS, "REG_KEYS", 32'(exp_keys));
                check_read(REG_LAST_CODE, "REG_LAST_CODE", 32'(exp_last));
                check_read(REG_PRESS_COUNT, "REG_PRESS_COUNT", 32'(exp_press));
                check_read(REG_ERR_COUNT, "REG_ERR_COUNT", 32'(exp_err));
        endtask

        task automatic send_code(input logic [7:0] code);
                send_frame(code, ~^code, 1'b1);
                apply_code(code);
                check_registers();
        endtask

        // A broken frame counts as an error and drops a pending break
        task automatic send_bad(input logic [7:0] code, input logic bad_stop);
                send_frame(code, bad_stop ? ~^code : ^code, ~bad_stop);
                if (exp_err != 16'hFFFF) begin
                        exp_err = exp_err + 16'd1;
                end
                after_break = 1'b0;
                check_registers();
        endtask

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("Timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
                $display("** FAIL **");
                $finish;
        end

        initial begin
                axi_data_t data;
                axi_resp_t resp;
                void'($urandom(20555));
                ps2_clk     = 1'b1;
                ps2_data    = 1'b1;
                awaddr      = '0;
                awvalid     = 1'b0;
                wdata       = '0;
                wvalid      = 1'b0;
                bready      = 1'b0;
                araddr      = '0;
                arvalid     = 1'b0;
                rready      = 1'b0;
                exp_keys    = '0;
                exp_last    = '0;
                exp_press   = '0;
                exp_err     = '0;
                after_break = 1'b0;
                errors      = 0;
                checks      = 0;
                frames_sent = 0;

                wait (rst_n === 1'b1);
                wait_cycles(2);
                check_registers();

                // Random set of presses
                for (int i = 0; i < 10; i++) begin
                        if ($urandom_range(0, 1) == 1) begin
                                send_code(key_codes[i]);
                        end
                end

                // Repeat, release and press again on S
                send_code(8'h1B);
                send_code(8'h1B);
                send_code(8'hF0);
                send_code(8'h1B);
                send_code(8'h1B);

                // Unmapped codes
                send_code(8'h15);
                send_code(8'h29);
                send_code(8'hF0);
                send_code(8'h29);

                // W released first, so a broken frame taken as valid would press it
                send_code(8'hF0);
                send_code(8'h1D);
                send_bad(8'h1D, 1'b0);
                send_bad(8'h1D, 1'b1);
                send_code(8'h1D);

                write_reg(REG_PRESS_COUNT, axi_data_t'($urandom()), resp);
                check_value("bresp", 32'(resp), 32'(RESP_OKAY));
                exp_press = '0;
                write_reg(REG_ERR_COUNT, axi_data_t'($urandom()), resp);
                check_value("bresp", 32'(resp), 32'(RESP_OKAY));
                exp_err = '0;
                write_reg(REG_KEYS, 32'h0, resp);
                check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
                write_reg(4'h2, 32'h0, resp);
                check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
                read_reg(4'h6, data, resp);
                check_value("rresp", 32'(resp), 32'(RESP_SLVERR));
                check_registers();

                // Counting resumes after the clear
                send_code(8'hF0);
                send_code(8'h75);
                send_code(8'h75);

                $display("Checks: %0d, errors: %0d, frames: %0d", checks, errors, frames_sent);
                if (errors == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/ps2_pkg.sv
logic/bus_pkg.sv
logic/key_status_if.sv
logic/ps2_frame_rx.sv
logic/scan_decode.sv
logic/key_state.sv
logic/key_axil_regs.sv
logic/ps2_keypad_top.sv
bench/tb_clock.sv
bench/ps2_keypad_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PS/2 keypad testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module ps2_keypad_tb -f compile.f

./obj_dir/Vps2_keypad_tb | tee sim.log

if grep -qF '** PASS **' sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed, see sim.log"
        exit 1
fi
